/* common/audio_pkg.sv */
// Audio sample types shared by the capture path
// One signed word per channel and the stereo frame built from two of them
`default_nettype none

package audio_pkg;

  //////////////////////////////////////////////////////////////////////
  // Word format
  //////////////////////////////////////////////////////////////////////

  // Console DAC format, 16 bit two's complement per channel
  localparam int AUDIO_WORD_BITS = 16;

  // Same word on the input and the output stream
  typedef logic signed [AUDIO_WORD_BITS-1:0] audio_word_t;

  //////////////////////////////////////////////////////////////////////
  // Stereo frame
  //////////////////////////////////////////////////////////////////////

  // One frame, left half first as on the wire
  // Also the storage unit of the sample buffer
  typedef struct packed {
    audio_word_t left;
    audio_word_t right;
  } stereo_sample_t;

endpackage

`default_nettype wire

/* common/i2s_pkg.sv */
// Serial audio line definitions
// Line bundle, in-word bit index and the state encodings of the serial blocks
`default_nettype none

package i2s_pkg;

  //////////////////////////////////////////////////////////////////////
  // Serial lines
  //////////////////////////////////////////////////////////////////////

  // Three-wire bundle, used for the console input and the HDMI output
  // lrclk high selects the left word, sdata valid at rising sclk
  typedef struct packed {
    logic sclk;
    logic lrclk;
    logic sdata;
  } i2s_lines_t;

  // Bit position inside a 16 bit word, MSB goes first
  typedef logic [3:0] bit_idx_t;

  // First bit sent or latched in each half
  localparam bit_idx_t BIT_IDX_MSB = 4'd15;

  //////////////////////////////////////////////////////////////////////
  // State encodings
  //////////////////////////////////////////////////////////////////////

  // Receiver, hunt for the first rising LRCLK before framing
  typedef enum logic {
    RX_HUNT,
    RX_FRAME
  } rx_state_t;

  // Transmitter, silence until the first sample shows up
  typedef enum logic {
    TX_WAIT,
    TX_STREAM
  } tx_state_t;

endpackage

`default_nettype wire

/* i2s_rx/i2s_sampler.sv */
// Console serial audio capture
// Synchronizes SCLK, LRCLK and SDATA and assembles one stereo frame per LRCLK period
`timescale 1ns/1ps
`default_nettype none

module i2s_sampler
  import audio_pkg::*;
  import i2s_pkg::*;
(
  input  wire logic       AMCLK_i,
  input  wire logic       nARST,
  input  wire i2s_lines_t ain_i,
  output stereo_sample_t  sample_o,
  output logic            push_o
);

  //////////////////////////////////////////////////////////////////////
  // Input synchronizer
  //////////////////////////////////////////////////////////////////////

  // Two flops against metastability, third one only for edge detection
  i2s_lines_t sync1_q;
  i2s_lines_t sync2_q;
  i2s_lines_t sync3_q;

  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      sync1_q <= '0;
      sync2_q <= '0;
      sync3_q <= '0;
    end else begin
      sync1_q <= ain_i;
      sync2_q <= sync1_q;
      sync3_q <= sync2_q;
    end
  end

  // Edge strobes, one AMCLK cycle wide
  logic sclk_rise;
  logic lr_rise;
  logic lr_fall;
  logic lr_edge;

  assign sclk_rise = sync2_q.sclk & ~sync3_q.sclk;
  assign lr_rise   = sync2_q.lrclk & ~sync3_q.lrclk;
  assign lr_fall   = ~sync2_q.lrclk & sync3_q.lrclk;
  assign lr_edge   = lr_rise | lr_fall;

  //////////////////////////////////////////////////////////////////////
  // Bit counter
  //////////////////////////////////////////////////////////////////////

  rx_state_t rx_state;
  bit_idx_t  bit_idx_q;
  bit_idx_t  cur_idx;
  logic      done_q;
  logic      cur_done;
  logic      capture;

  // An LRCLK edge restarts the half in the same cycle,
  // so a coincident SCLK edge already lands on the MSB
  assign cur_idx  = lr_edge ? BIT_IDX_MSB : bit_idx_q;
  assign cur_done = lr_edge ? 1'b0 : done_q;

  // Bits past the 16th are ignored
  assign capture = sclk_rise & ~cur_done;

  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      rx_state  <= RX_HUNT;
      bit_idx_q <= BIT_IDX_MSB;
      // Nothing is captured before the first LRCLK edge
      done_q    <= 1'b1;
      push_o    <= 1'b0;
    end else begin
      push_o <= 1'b0;

      if (capture) begin
        bit_idx_q <= cur_idx - bit_idx_t'(1);
        done_q    <= (cur_idx == '0);
      end else if (lr_edge) begin
        bit_idx_q <= BIT_IDX_MSB;
        done_q    <= 1'b0;
      end

      // Rising LRCLK closes the right half and with it the frame
      // The very first one only starts framing, its frame was partial
      if (lr_rise) begin
        if (rx_state == RX_HUNT) begin
          rx_state <= RX_FRAME;
        end else begin
          push_o <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Word assembly
  //////////////////////////////////////////////////////////////////////

  audio_word_t left_q;
  audio_word_t right_q;

  always_ff @(posedge AMCLK_i) begin
    // New half starts from a cleared word
    // so short words keep zero low bits
    if (lr_edge) begin
      if (sync2_q.lrclk) begin
        left_q <= '0;
      end else begin
        right_q <= '0;
      end
    end

    // LRCLK level picks the target word, bit written by index
    if (capture) begin
      if (sync2_q.lrclk) begin
        left_q[cur_idx] <= sync2_q.sdata;
      end else begin
        right_q[cur_idx] <= sync2_q.sdata;
      end
    end

    // Frame handed out together with push_o
    if (lr_rise) begin
      sample_o.left  <= left_q;
      sample_o.right <= right_q;
    end
  end

endmodule

`default_nettype wire

/* verilog/sample_fifo.sv */
// Stereo sample buffer between console rate and output rate
// First word fall-through, drops pushes while full and flags the loss
`timescale 1ns/1ps
`default_nettype none

module sample_fifo
  import audio_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
) (
  input  wire logic           AMCLK_i,
  input  wire logic           nARST,
  input  wire logic           push_i,
  input  wire stereo_sample_t sample_i,
  input  wire logic           pop_i,
  output stereo_sample_t      head_o,
  output logic                empty_o,
  output logic                overflow_o
);

  // Depth is a power of two, pointers carry one extra wrap bit
  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [ADDR_W:0]   ptr_t;

  //////////////////////////////////////////////////////////////////////
  // Pointers and status
  //////////////////////////////////////////////////////////////////////

  stereo_sample_t mem_q [FIFO_DEPTH];
  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  addr_t wr_addr;
  addr_t rd_addr;
  logic  full;
  logic  wr_en;

  assign wr_addr = wr_ptr_q[ADDR_W-1:0];
  assign rd_addr = rd_ptr_q[ADDR_W-1:0];

  // Same address, different lap means full
  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full    = (wr_addr == rd_addr) && (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]);

  // A push into a full buffer is lost
  assign wr_en = push_i & ~full;

  // Oldest entry always on the head, valid while not empty
  assign head_o = mem_q[rd_addr];

  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      end
      // Serializer only pops while not empty
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
      // Sticky until reset
      if (push_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge AMCLK_i) begin
    if (wr_en) begin
      mem_q[wr_addr] <= sample_i;
    end
  end

endmodule

`default_nettype wire

/* i2s_tx/i2s_serializer.sv */
// Serial audio output towards the HDMI transmitter
// Divides AMCLK into the bit clock and shifts out one buffered frame per LRCLK period
`timescale 1ns/1ps
`default_nettype none

module i2s_serializer
  import audio_pkg::*;
  import i2s_pkg::*;
#(
  parameter int SCLK_DIV = 4
) (
  input  wire logic           AMCLK_i,
  input  wire logic           nARST,
  input  wire stereo_sample_t head_i,
  input  wire logic           empty_i,
  output logic                pop_o,
  output i2s_lines_t          aout_o,
  output logic                underflow_o
);

  // Bit period is 2 x SCLK_DIV AMCLK cycles
  localparam int DIV_W = $clog2(2 * SCLK_DIV);

  typedef logic [DIV_W-1:0] div_cnt_t;
  // Bit period within the frame, MSB set in the right half
  typedef logic [4:0] period_t;

  localparam div_cnt_t DIV_LAST    = div_cnt_t'(2 * SCLK_DIV - 1);
  localparam div_cnt_t DIV_RISE    = div_cnt_t'(SCLK_DIV - 1);
  localparam period_t  PERIOD_LAST = 5'd31;

  //////////////////////////////////////////////////////////////////////
  // Bit timing
  //////////////////////////////////////////////////////////////////////

  div_cnt_t       div_q;
  period_t        period_q;
  period_t        period_nxt;
  bit_idx_t       idx_nxt;
  logic           period_end;
  logic           sclk_rise;
  logic           frame_start;
  logic           framing_q;
  tx_state_t      tx_state;
  stereo_sample_t word_q;
  stereo_sample_t load_sample;
  stereo_sample_t src_sample;
  logic           sdata_nxt;

  assign period_end  = (div_q == DIV_LAST);
  // SCLK stays low until the first frame has started
  assign sclk_rise   = (div_q == DIV_RISE) & framing_q;
  assign frame_start = period_end & (period_q == PERIOD_LAST);

  assign period_nxt = period_q + period_t'(1);
  // Period 0 and 16 carry bit 15
  assign idx_nxt    = BIT_IDX_MSB - bit_idx_t'(period_nxt[3:0]);

  // Empty buffer gives a silent frame
  assign load_sample = empty_i ? '0 : head_i;
  // At frame start the MSB comes straight from the new frame
  assign src_sample  = frame_start ? load_sample : word_q;
  assign sdata_nxt   = period_nxt[4] ? src_sample.right[idx_nxt]
                                     : src_sample.left[idx_nxt];

  //////////////////////////////////////////////////////////////////////
  // Line generation and buffer control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge AMCLK_i) begin
    if (!nARST) begin
      div_q       <= '0;
      // Parked in the last period, first frame after one bit period
      period_q    <= PERIOD_LAST;
      framing_q   <= 1'b0;
      tx_state    <= TX_WAIT;
      pop_o       <= 1'b0;
      underflow_o <= 1'b0;
      aout_o      <= '0;
    end else begin
      pop_o <= 1'b0;
      div_q <= period_end ? '0 : div_q + div_cnt_t'(1);

      // Second half of the bit period has SCLK high
      if (sclk_rise) begin
        aout_o.sclk <= 1'b1;
      end

      // SDATA and LRCLK only move at the start of a period
      if (period_end) begin
        period_q     <= period_nxt;
        aout_o.sclk  <= 1'b0;
        aout_o.lrclk <= ~period_nxt[4];
        aout_o.sdata <= sdata_nxt;
      end

      // Pop lines up with the first cycle of the frame
      if (frame_start) begin
        framing_q <= 1'b1;
        pop_o     <= ~empty_i;
        if (!empty_i) begin
          tx_state <= TX_STREAM;
        end else if (tx_state == TX_STREAM) begin
          // Starved once streaming, sticky
          underflow_o <= 1'b1;
        end
      end
    end
  end

  // Frame held for the 32 bit periods
  always_ff @(posedge AMCLK_i) begin
    if (frame_start) begin
      word_q <= load_sample;
    end
  end

endmodule

`default_nettype wire

/* verilog/audio_path_top.sv */
// Audio capture path top level
// Console serial input, sample buffer and regenerated serial output
`timescale 1ns/1ps
`default_nettype none

module audio_path_top
  import audio_pkg::*;
  import i2s_pkg::*;
#(
  parameter int FIFO_DEPTH = 8,
  parameter int SCLK_DIV   = 4
) (
  input  wire logic       AMCLK_i,
  input  wire logic       nARST,
  input  wire i2s_lines_t ain_i,
  output i2s_lines_t      aout_o,
  output logic            overflow_o,
  output logic            underflow_o
);

  // Sampler to buffer
  stereo_sample_t rx_sample;
  logic           push;

  // Buffer to serializer
  stereo_sample_t head;
  logic           empty;
  logic           pop;

  i2s_sampler u_sampler (
    .AMCLK_i  (AMCLK_i),
    .nARST    (nARST),
    .ain_i    (ain_i),
    .sample_o (rx_sample),
    .push_o   (push)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .AMCLK_i    (AMCLK_i),
    .nARST      (nARST),
    .push_i     (push),
    .sample_i   (rx_sample),
    .pop_i      (pop),
    .head_o     (head),
    .empty_o    (empty),
    .overflow_o (overflow_o)
  );

  i2s_serializer #(
    .SCLK_DIV (SCLK_DIV)
  ) u_serializer (
    .AMCLK_i     (AMCLK_i),
    .nARST       (nARST),
    .head_i      (head),
    .empty_i     (empty),
    .pop_o       (pop),
    .aout_o      (aout_o),
    .underflow_o (underflow_o)
  );

endmodule

`default_nettype wire

/* bench/tb_audio_path.sv */
// Testbench for the audio capture path
// Plays serial frames from the vector file and rebuilds the regenerated output stream
`timescale 1ns/1ps
`default_nettype none

module tb_audio_path
  import audio_pkg::*;
  import i2s_pkg::*;
;

  localparam int FIFO_DEPTH = 8;
  localparam int SCLK_DIV   = 4;
  localparam int FRAME_CYC  = 64 * SCLK_DIV;

  logic       AMCLK_i = 1'b0;
  logic       nARST;
  i2s_lines_t ain;
  i2s_lines_t aout;
  logic       overflow;
  logic       underflow;

  audio_path_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .SCLK_DIV   (SCLK_DIV)
  ) dut (
    .AMCLK_i     (AMCLK_i),
    .nARST       (nARST),
    .ain_i       (ain),
    .aout_o      (aout),
    .overflow_o  (overflow),
    .underflow_o (underflow)
  );

  always #5 AMCLK_i = ~AMCLK_i;

  // Parsed vector lines with kind 0 for a section, 1 for a frame and 2 for a pause
  int vkind[$];
  int va[$];
  int vb[$];
  int vc[$];
  int vd[$];

  // Expected output words and whether each one must arrive
  stereo_sample_t exp_q[$];
  bit             must_q[$];
  int             exp_ptr = 0;

  int  value_errs  = 0;
  int  other_errs  = 0;
  int  zero_frames = 0;
  int  cycles      = 0;
  int  limit       = 2000000;
  int  cur_sec     = 0;
  int  burst_cnt   = 0;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_sample(input string name, input stereo_sample_t exp,
                              input stereo_sample_t act);
    if (exp !== act) begin
      value_errs++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      value_errs++;
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////////////////////////

  // Output words walk the expected list in order
  // Only dropped burst entries may be skipped
  task automatic match_frame(input stereo_sample_t got);
    int j;
    j = exp_ptr;
    while (j < exp_q.size() && exp_q[j] != got) begin
      j++;
    end
    if (j == exp_q.size()) begin
      if (exp_ptr < exp_q.size()) begin
        check_sample("aout_o frame", exp_q[exp_ptr], got);
        exp_ptr++;
      end else begin
        other_errs++;
        $display("Unexpected output frame %h at %0t", got, $time);
      end
    end else begin
      for (int k = exp_ptr; k < j; k++) begin
        if (must_q[k]) begin
          other_errs++;
          $display("Frame %h never appeared on the output", exp_q[k]);
        end
      end
      check_sample("aout_o frame", exp_q[j], got);
      exp_ptr = j + 1;
    end
  endtask

  stereo_sample_t mon_word;
  logic           sclk_prev = 1'b0;
  logic           in_left   = 1'b0;
  int             lcnt      = 0;
  int             rcnt      = 0;

  always @(posedge AMCLK_i) begin
    if (aout.sclk === 1'b1 && sclk_prev === 1'b0) begin
      if (aout.lrclk) begin
        // Rising lrclk opens a new frame
        if (!in_left) begin
          in_left = 1'b1;
          lcnt    = 0;
          rcnt    = 0;
        end
        mon_word.left = {mon_word.left[14:0], aout.sdata};
        lcnt++;
      end else begin
        in_left        = 1'b0;
        mon_word.right = {mon_word.right[14:0], aout.sdata};
        rcnt++;
        if (rcnt == 16 && lcnt == 16) begin
          if (mon_word == '0) begin
            zero_frames++;
          end else begin
            match_frame(mon_word);
          end
        end
      end
    end
    sclk_prev = aout.sclk;
  end

  // Run limit
  always @(posedge AMCLK_i) begin
    cycles++;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, the output stream did not drain", cycles);
      $display("Errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Input driver
  //////////////////////////////////////////////////////////////////////

  task automatic send_half(input logic lr, input logic [31:0] val, input int bits,
                           input int half);
    for (int i = bits - 1; i >= 0; i--) begin
      ain.lrclk <= lr;
      ain.sclk  <= 1'b0;
      ain.sdata <= val[i];
      repeat (half) @(posedge AMCLK_i);
      ain.sclk <= 1'b1;
      repeat (half) @(posedge AMCLK_i);
    end
  endtask

  // Expected word is the first 16 bits sent with zero padding below
  function automatic audio_word_t first16(input logic [31:0] val, input int bits);
    logic [31:0] w;
    w = (bits > 16) ? (val >> (bits - 16)) : (val << (16 - bits));
    return audio_word_t'(w[15:0]);
  endfunction

  task automatic send_frame(input logic [31:0] l, input logic [31:0] r, input int bits,
                            input int half);
    stereo_sample_t s;
    s.left  = first16(l, bits);
    s.right = first16(r, bits);
    // Random phase of the SCLK edges
    repeat ($urandom % 4) @(posedge AMCLK_i);
    // Each frame is pushed by the next rising LRCLK
    exp_q.push_back(s);
    must_q.push_back(cur_sec != 5 || burst_cnt < FIFO_DEPTH);
    if (cur_sec == 5) begin
      burst_cnt++;
    end
    send_half(1'b1, l, bits, half);
    send_half(1'b0, r, bits, half);
  endtask

  task automatic end_section(input int sec);
    case (sec)
      1: begin
        check_flag("overflow_o", 1'b0, overflow);
        check_flag("underflow_o", 1'b0, underflow);
      end
      // Slower input leaves silent gaps and underflow may rise
      2, 3: check_flag("overflow_o", 1'b0, overflow);
      4: check_flag("underflow_o", 1'b1, underflow);
      5: begin
        check_flag("overflow_o", 1'b1, overflow);
        check_flag("underflow_o", 1'b1, underflow);
      end
      default: ;
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int    fd;
    int    rc;
    int    z0;
    int    a;
    int    b;
    int    c;
    int    d;
    string line;
    string kw;
    void'($urandom(32'h457e_a029));
    nARST <= 1'b0;
    ain   <= '0;

    fd = $fopen("bench/audio_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file");
      $display("Errors found");
      $finish;
    end else begin
      limit = 20 * FRAME_CYC + 100;
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        if (rc > 0 && line.substr(0, 0) != "#") begin
          rc = $sscanf(line, "%s", kw);
          // Pause lengths are decimal and frame words hex
          if (rc == 1 && kw == "P") begin
            rc = $sscanf(line, "%s %d", kw, a);
          end else begin
            rc = $sscanf(line, "%s %h %h %d %d", kw, a, b, c, d);
          end
          if (rc >= 2) begin
            vkind.push_back(kw == "S" ? 0 : (kw == "F" ? 1 : 2));
            va.push_back(a);
            vb.push_back(b);
            vc.push_back(c);
            vd.push_back(d);
            if (kw == "F") limit += 34 * c * d;
            if (kw == "P") limit += a;
          end
        end
      end
      $fclose(fd);

      repeat (5) @(posedge AMCLK_i);
      nARST <= 1'b1;
      // Lines stay low until the first output frame starts
      repeat (2 * SCLK_DIV) begin
        @(posedge AMCLK_i);
        check_flag("aout_o", 1'b0, |aout);
      end
      // First frame opens with lrclk high
      @(posedge AMCLK_i);
      check_flag("aout_o.lrclk", 1'b1, aout.lrclk);

      for (int i = 0; i < vkind.size(); i++) begin
        case (vkind[i])
          0: begin
            if (cur_sec != 0) end_section(cur_sec);
            cur_sec = va[i];
            $display("Section %0d at %0t", cur_sec, $time);
          end
          1: send_frame(va[i], vb[i], vc[i], vd[i]);
          default: begin
            z0 = zero_frames;
            repeat (va[i]) @(posedge AMCLK_i);
            if ((cur_sec == 1 || cur_sec == 4) && zero_frames < z0 + 2) begin
              other_errs++;
              $display("Output frames during the input pause were not silent");
            end
          end
        endcase
      end

      // Closing rising LRCLK pushes the last frame
      // Then the output drains into silence
      @(posedge AMCLK_i);
      ain.lrclk <= 1'b1;
      ain.sclk  <= 1'b0;
      z0 = zero_frames;
      while (zero_frames < z0 + 2) @(posedge AMCLK_i);
      end_section(cur_sec);
      for (int k = exp_ptr; k < exp_q.size(); k++) begin
        if (must_q[k]) begin
          other_errs++;
          $display("Frame %h never appeared on the output", exp_q[k]);
        end
      end

      $display("value errors %0d, other errors %0d", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* bench/audio_vectors.txt */
# S section name | F left right bits half (left, right in hex, bits per half, half period)
# P cycles of input pause, lines held
S 1 idle
P 1200
S 2 normal
F 1234 abcd 16 5
F 7fff 8000 16 5
F 0101 fefe 16 5
F 5a5a a5a5 16 5
F 1357 2468 16 6
F 7001 0e02 16 5
S 3 wordlen
F 2d5a3 1c3b7 18 4
F 3ffff 20001 18 4
F a5c 3f1 12 6
F 801 7ff 12 6
S 4 pause
F 4321 8765 16 5
P 2400
F 6c6c 1d1d 16 5
F 0f0f f0f0 16 5
S 5 burst
F 1001 2001 16 1
F 1002 2002 16 1
F 1003 2003 16 1
F 1004 2004 16 1
F 1005 2005 16 1
F 1006 2006 16 1
F 1007 2007 16 1
F 1008 2008 16 1
F 1009 2009 16 1
F 100a 200a 16 1
F 100b 200b 16 1
F 100c 200c 16 1
F 100d 200d 16 1
F 100e 200e 16 1
F 100f 200f 16 1
F 1010 2010 16 1

/* sources.f */
common/audio_pkg.sv
common/i2s_pkg.sv
i2s_rx/i2s_sampler.sv
verilog/sample_fifo.sv
i2s_tx/i2s_serializer.sv
verilog/audio_path_top.sv
bench/tb_audio_path.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the audio path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f sources.f --top-module tb_audio_path -o tb_audio_path \
  && ./obj_dir/tb_audio_path | tee /dev/stderr | grep -q "No errors" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
